// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

   localparam int unsigned DATA_WIDTH         = 32;
   localparam int unsigned MEM_ADDR_WIDTH     = 10;  // Byte address, 1 KiB
   localparam int unsigned REG_ADDR_WIDTH     = 5;
   localparam int unsigned LOAD_OP_WIDTH      = 3;
   localparam int unsigned MEM_TRANSFER_WIDTH = 2;

   // Load kinds, same codes as RISC-V funct3
   localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LB  = 3'd0;
   localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LH  = 3'd1;
   localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LW  = 3'd2;
   localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LBU = 3'd4;
   localparam logic [LOAD_OP_WIDTH-1:0] LOAD_LHU = 3'd5;

   // Store sizes
   localparam logic [MEM_TRANSFER_WIDTH-1:0] XFER_BYTE = 2'd0;
   localparam logic [MEM_TRANSFER_WIDTH-1:0] XFER_HALF = 2'd1;
   localparam logic [MEM_TRANSFER_WIDTH-1:0] XFER_WORD = 2'd2;

   localparam int unsigned DMEM_WAIT_CYCLES = 1;  // Req held this long before gnt
   localparam int unsigned DMEM_WAIT_WIDTH  = $clog2(DMEM_WAIT_CYCLES + 1);
   localparam int unsigned DMEM_WORDS       = 2 ** (MEM_ADDR_WIDTH - 2);

   // Memory stage bus FSM
   localparam int unsigned MEM_STATE_WIDTH = 2;
   localparam logic [MEM_STATE_WIDTH-1:0] MEM_IDLE  = 2'd0;
   localparam logic [MEM_STATE_WIDTH-1:0] MEM_READ  = 2'd1;
   localparam logic [MEM_STATE_WIDTH-1:0] MEM_WRITE = 2'd2;

   // One loaded word, seen as byte lanes or as halfword lanes
   typedef union packed
   {
      logic [3:0][7:0]  bytes;
      logic [1:0][15:0] halves;
   } load_word_u;

endpackage

`default_nettype wire

// ==== design/data_sram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_sram
(
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire                                      req_i,
   input  wire                                      wr_i,
   input  wire  [core_pkg::MEM_ADDR_WIDTH-1:0]      addr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]          wdata_i,
   input  wire  [core_pkg::MEM_TRANSFER_WIDTH-1:0]  xfer_i,
   output logic                                     gnt_o,
   output logic                                     rvalid_o,
   output logic [core_pkg::DATA_WIDTH-1:0]          rdata_o
);
   import core_pkg::*;

   logic [DATA_WIDTH-1:0]       mem [DMEM_WORDS];
   logic [DMEM_WAIT_WIDTH-1:0]  wait_cnt;
   logic [MEM_ADDR_WIDTH-3:0]   word_idx;
   logic [3:0]                  byte_en;
   logic [DATA_WIDTH-1:0]       lane_data;

   assign word_idx = addr_i[MEM_ADDR_WIDTH-1:2];
   assign gnt_o    = req_i && (wait_cnt == DMEM_WAIT_WIDTH'(DMEM_WAIT_CYCLES));

   // Counts cycles a request has been held
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wait_cnt <= '0;
         rvalid_o <= 1'b0;
      end
      else
      begin
         if (!req_i || gnt_o)
            wait_cnt <= '0;
         else
            wait_cnt <= wait_cnt + 1'b1;
         rvalid_o <= gnt_o && !wr_i;
      end
   end

   // Lanes from size and offset, data replicated from the low bits
   always_comb
   begin
      case (xfer_i)
         XFER_BYTE:
         begin
            byte_en   = 4'b0001 << addr_i[1:0];
            lane_data = {4{wdata_i[7:0]}};
         end
         XFER_HALF:
         begin
            byte_en   = 4'b0011 << {addr_i[1], 1'b0};
            lane_data = {2{wdata_i[15:0]}};
         end
         default:
         begin
            byte_en   = 4'b1111;   // Word
            lane_data = wdata_i;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (gnt_o && wr_i)
      begin
         for (int i = 0; i < 4; i++)
         begin
            if (byte_en[i])
               mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
         end
      end
      if (gnt_o && !wr_i)
         rdata_o <= mem[word_idx];   // Full aligned word
   end

   // Waiting request stays steady until grant
   assert property (@(posedge clk) disable iff (!rst_n)
      (req_i && !gnt_o) |=> (req_i && $stable(wr_i) && $stable(addr_i)));

endmodule

`default_nettype wire

// ==== design/core_mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_mem_stage
(
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire  [core_pkg::REG_ADDR_WIDTH-1:0]      m_regfile_waddr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]          m_regfile_rd_i,
   input  wire                                      m_regfile_wr_i,
   input  wire                                      m_data_rd_i,
   input  wire                                      m_data_wr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]          m_data_addr_i,
   input  wire  [core_pkg::MEM_TRANSFER_WIDTH-1:0]  m_data_write_transfer_i,
   input  wire  [core_pkg::LOAD_OP_WIDTH-1:0]       m_load_op_i,
   input  wire                                      m_is_load_store_i,
   input  wire                                      data_gnt_i,
   input  wire                                      data_rvalid_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]          data_rdata_i,
   output logic                                     data_req_o,
   output logic                                     data_wr_o,
   output logic [core_pkg::MEM_ADDR_WIDTH-1:0]      data_addr_o,
   output logic [core_pkg::DATA_WIDTH-1:0]          data_wdata_o,
   output logic [core_pkg::MEM_TRANSFER_WIDTH-1:0]  data_write_transfer_o,
   output logic                                     stall_o,
   output logic [core_pkg::REG_ADDR_WIDTH-1:0]      w_regfile_waddr_o,
   output logic [core_pkg::DATA_WIDTH-1:0]          w_regfile_rd_o,
   output logic                                     w_regfile_wr_o,
   output logic                                     w_is_load_store_o,
   output logic [core_pkg::LOAD_OP_WIDTH-1:0]       w_load_op_o,
   output logic [1:0]                               w_byte_off_o,
   output logic [core_pkg::DATA_WIDTH-1:0]          w_data_rdata_o
);
   import core_pkg::*;

   logic [MEM_STATE_WIDTH-1:0] state;
   logic [MEM_STATE_WIDTH-1:0] next_state;
   logic [1:0]                 align_mask;

   // No new request while read data is still outstanding
   assign data_req_o            = (m_data_rd_i | m_data_wr_i) && (state != MEM_READ);
   assign data_wr_o             = m_data_wr_i;
   assign data_addr_o           = m_data_addr_i[MEM_ADDR_WIDTH-1:0];
   assign data_wdata_o          = m_regfile_rd_i;
   assign data_write_transfer_o = m_data_write_transfer_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= MEM_IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         MEM_IDLE:
         begin
            if (m_data_rd_i && data_gnt_i)
               next_state = MEM_READ;     // Read accepted, wait for rvalid
            else if (m_data_wr_i && !data_gnt_i)
               next_state = MEM_WRITE;    // Store waiting for grant
         end
         MEM_READ:
         begin
            if (data_rvalid_i)
               next_state = MEM_IDLE;
         end
         MEM_WRITE:
         begin
            if (data_gnt_i)
               next_state = MEM_IDLE;
         end
         default:
            next_state = MEM_IDLE;
      endcase
   end

   always_comb
   begin
      case (state)
         MEM_READ:  stall_o = !data_rvalid_i;
         MEM_WRITE: stall_o = !data_gnt_i;
         default:   stall_o = m_data_rd_i || (m_data_wr_i && !data_gnt_i);
      endcase
   end

   // Control part of the writeback register, bubble while stalled
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         w_regfile_wr_o    <= 1'b0;
         w_is_load_store_o <= 1'b0;
      end
      else if (stall_o)
      begin
         w_regfile_wr_o    <= 1'b0;
         w_is_load_store_o <= 1'b0;
      end
      else
      begin
         w_regfile_wr_o    <= m_regfile_wr_i;
         w_is_load_store_o <= m_is_load_store_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall_o)
      begin
         w_regfile_waddr_o <= m_regfile_waddr_i;
         w_regfile_rd_o    <= m_regfile_rd_i;
         w_load_op_o       <= m_load_op_i;
         w_byte_off_o      <= m_data_addr_i[1:0];
      end
      if (data_rvalid_i)
         w_data_rdata_o <= data_rdata_i;    // Stall ends in this same cycle
   end

   // Address bits that must be zero for the access size
   always_comb
   begin
      align_mask = 2'b00;
      if (m_data_wr_i)
      begin
         if (m_data_write_transfer_i == XFER_WORD)
            align_mask = 2'b11;
         else if (m_data_write_transfer_i == XFER_HALF)
            align_mask = 2'b01;
      end
      else if (m_data_rd_i)
      begin
         if (m_load_op_i == LOAD_LW)
            align_mask = 2'b11;
         else if ((m_load_op_i == LOAD_LH) || (m_load_op_i == LOAD_LHU))
            align_mask = 2'b01;
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      data_req_o |-> ((m_data_addr_i[1:0] & align_mask) == 2'b00));

   assert property (@(posedge clk) disable iff (!rst_n)
      !(m_data_rd_i && m_data_wr_i));

   // Memory must grant a waiting store by the cycle after it was raised
   assert property (@(posedge clk) disable iff (!rst_n)
      (state == MEM_WRITE) |-> !stall_o);

endmodule

`default_nettype wire

// ==== design/core_wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_wb_stage
(
   input  wire  [core_pkg::REG_ADDR_WIDTH-1:0]  w_regfile_waddr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]      w_regfile_rd_i,
   input  wire                                  w_regfile_wr_i,
   input  wire                                  w_is_load_store_i,
   input  wire  [core_pkg::LOAD_OP_WIDTH-1:0]   w_load_op_i,
   input  wire  [1:0]                           w_byte_off_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]      w_data_rdata_i,
   output logic                                 rf_we_o,
   output logic [core_pkg::REG_ADDR_WIDTH-1:0]  rf_waddr_o,
   output logic [core_pkg::DATA_WIDTH-1:0]      rf_wdata_o
);
   import core_pkg::*;

   load_word_u            load_word;
   logic [7:0]            load_byte;
   logic [15:0]           load_half;
   logic [DATA_WIDTH-1:0] load_value;

   assign load_word = w_data_rdata_i;
   assign load_byte = load_word.bytes[w_byte_off_i];
   assign load_half = load_word.halves[w_byte_off_i[1]];   // Offset bit 0 is zero here

   always_comb
   begin
      case (w_load_op_i)
         LOAD_LB:
            load_value = {{(DATA_WIDTH - 8){load_byte[7]}}, load_byte};
         LOAD_LBU:
            load_value = {{(DATA_WIDTH - 8){1'b0}}, load_byte};
         LOAD_LH:
            load_value = {{(DATA_WIDTH - 16){load_half[15]}}, load_half};
         LOAD_LHU:
            load_value = {{(DATA_WIDTH - 16){1'b0}}, load_half};
         default:
            load_value = load_word;   // LW
      endcase
   end

   // Stores reach here with write enable low
   assign rf_we_o    = w_regfile_wr_i;
   assign rf_waddr_o = w_regfile_waddr_i;
   assign rf_wdata_o = w_is_load_store_i ? load_value : w_regfile_rd_i;

endmodule

`default_nettype wire

// ==== design/core_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_regfile
(
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire                                  we_i,
   input  wire  [core_pkg::REG_ADDR_WIDTH-1:0]  waddr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]      wdata_i,
   input  wire  [core_pkg::REG_ADDR_WIDTH-1:0]  raddr_i,
   output logic [core_pkg::DATA_WIDTH-1:0]      rdata_o
);
   import core_pkg::*;

   logic [DATA_WIDTH-1:0] regs [1:(2 ** REG_ADDR_WIDTH) - 1];   // No storage for x0

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 1; i < 2 ** REG_ADDR_WIDTH; i++)
            regs[i] <= '0;
      end
      else if (we_i && (waddr_i != '0))
      begin
         regs[waddr_i] <= wdata_i;
      end
   end

   assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];   // x0 reads as zero

endmodule

`default_nettype wire

// ==== design/core_lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_lsu_top
(
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire  [core_pkg::REG_ADDR_WIDTH-1:0]      m_regfile_waddr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]          m_regfile_rd_i,
   input  wire                                      m_regfile_wr_i,
   input  wire                                      m_data_rd_i,
   input  wire                                      m_data_wr_i,
   input  wire  [core_pkg::DATA_WIDTH-1:0]          m_data_addr_i,
   input  wire  [core_pkg::MEM_TRANSFER_WIDTH-1:0]  m_data_write_transfer_i,
   input  wire  [core_pkg::LOAD_OP_WIDTH-1:0]       m_load_op_i,
   input  wire                                      m_is_load_store_i,
   output logic                                     stall_o,
   input  wire  [core_pkg::REG_ADDR_WIDTH-1:0]      rf_raddr_i,
   output logic [core_pkg::DATA_WIDTH-1:0]          rf_rdata_o
);
   import core_pkg::*;

   // Data bus
   logic                          data_req;
   logic                          data_wr;
   logic [MEM_ADDR_WIDTH-1:0]     data_addr;
   logic [DATA_WIDTH-1:0]         data_wdata;
   logic [MEM_TRANSFER_WIDTH-1:0] data_xfer;
   logic                          data_gnt;
   logic                          data_rvalid;
   logic [DATA_WIDTH-1:0]         data_rdata;

   // Memory to writeback register
   logic [REG_ADDR_WIDTH-1:0]     w_regfile_waddr;
   logic [DATA_WIDTH-1:0]         w_regfile_rd;
   logic                          w_regfile_wr;
   logic                          w_is_load_store;
   logic [LOAD_OP_WIDTH-1:0]      w_load_op;
   logic [1:0]                    w_byte_off;
   logic [DATA_WIDTH-1:0]         w_data_rdata;

   // Register file write port
   logic                          rf_we;
   logic [REG_ADDR_WIDTH-1:0]     rf_waddr;
   logic [DATA_WIDTH-1:0]         rf_wdata;

   core_mem_stage u_mem_stage
   (
      .clk                     (clk),
      .rst_n                   (rst_n),
      .m_regfile_waddr_i       (m_regfile_waddr_i),
      .m_regfile_rd_i          (m_regfile_rd_i),
      .m_regfile_wr_i          (m_regfile_wr_i),
      .m_data_rd_i             (m_data_rd_i),
      .m_data_wr_i             (m_data_wr_i),
      .m_data_addr_i           (m_data_addr_i),
      .m_data_write_transfer_i (m_data_write_transfer_i),
      .m_load_op_i             (m_load_op_i),
      .m_is_load_store_i       (m_is_load_store_i),
      .data_gnt_i              (data_gnt),
      .data_rvalid_i           (data_rvalid),
      .data_rdata_i            (data_rdata),
      .data_req_o              (data_req),
      .data_wr_o               (data_wr),
      .data_addr_o             (data_addr),
      .data_wdata_o            (data_wdata),
      .data_write_transfer_o   (data_xfer),
      .stall_o                 (stall_o),
      .w_regfile_waddr_o       (w_regfile_waddr),
      .w_regfile_rd_o          (w_regfile_rd),
      .w_regfile_wr_o          (w_regfile_wr),
      .w_is_load_store_o       (w_is_load_store),
      .w_load_op_o             (w_load_op),
      .w_byte_off_o            (w_byte_off),
      .w_data_rdata_o          (w_data_rdata)
   );

   data_sram u_data_sram
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_i    (data_req),
      .wr_i     (data_wr),
      .addr_i   (data_addr),
      .wdata_i  (data_wdata),
      .xfer_i   (data_xfer),
      .gnt_o    (data_gnt),
      .rvalid_o (data_rvalid),
      .rdata_o  (data_rdata)
   );

   core_wb_stage u_wb_stage
   (
      .w_regfile_waddr_i (w_regfile_waddr),
      .w_regfile_rd_i    (w_regfile_rd),
      .w_regfile_wr_i    (w_regfile_wr),
      .w_is_load_store_i (w_is_load_store),
      .w_load_op_i       (w_load_op),
      .w_byte_off_i      (w_byte_off),
      .w_data_rdata_i    (w_data_rdata),
      .rf_we_o           (rf_we),
      .rf_waddr_o        (rf_waddr),
      .rf_wdata_o        (rf_wdata)
   );

   core_regfile u_regfile
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (rf_we),
      .waddr_i (rf_waddr),
      .wdata_i (rf_wdata),
      .raddr_i (rf_raddr_i),
      .rdata_o (rf_rdata_o)
   );

endmodule

`default_nettype wire

// ==== dv/tb_core_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_core_lsu;
   import core_pkg::*;

   logic                          clk;
   logic                          rst_n;
   logic [REG_ADDR_WIDTH-1:0]     m_regfile_waddr_i;
   logic [DATA_WIDTH-1:0]         m_regfile_rd_i;
   logic                          m_regfile_wr_i;
   logic                          m_data_rd_i;
   logic                          m_data_wr_i;
   logic [DATA_WIDTH-1:0]         m_data_addr_i;
   logic [MEM_TRANSFER_WIDTH-1:0] m_data_write_transfer_i;
   logic [LOAD_OP_WIDTH-1:0]      m_load_op_i;
   logic                          m_is_load_store_i;
   logic                          stall_o;
   logic [REG_ADDR_WIDTH-1:0]     rf_raddr_i;
   logic [DATA_WIDTH-1:0]         rf_rdata_o;

   logic [15:0] lfsr_state = 16'd43176;
   int          trace_fd;
   int          test_errors = 0;
   int          test_checks = 0;
   int          total_errors = 0;
   int          total_checks = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   core_lsu_top i_dut
   (
      .clk                     (clk),
      .rst_n                   (rst_n),
      .m_regfile_waddr_i       (m_regfile_waddr_i),
      .m_regfile_rd_i          (m_regfile_rd_i),
      .m_regfile_wr_i          (m_regfile_wr_i),
      .m_data_rd_i             (m_data_rd_i),
      .m_data_wr_i             (m_data_wr_i),
      .m_data_addr_i           (m_data_addr_i),
      .m_data_write_transfer_i (m_data_write_transfer_i),
      .m_load_op_i             (m_load_op_i),
      .m_is_load_store_i       (m_is_load_store_i),
      .stall_o                 (stall_o),
      .rf_raddr_i              (rf_raddr_i),
      .rf_rdata_o              (rf_rdata_o)
   );

   always #2 clk = ~clk;   // 4 ns period

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] word;
      word = '0;
      for (int b = 0; b < 32; b++)
      begin
         lfsr_state = lfsr_step(lfsr_state);   // One step per bit
         word       = {word[30:0], lfsr_state[0]};
      end
      return word;
   endfunction

   task automatic drive_idle();
      m_regfile_waddr_i       = '0;
      m_regfile_rd_i          = '0;
      m_regfile_wr_i          = 1'b0;
      m_data_rd_i             = 1'b0;
      m_data_wr_i             = 1'b0;
      m_data_addr_i           = '0;
      m_data_write_transfer_i = '0;
      m_load_op_i             = '0;
      m_is_load_store_i       = 1'b0;
   endtask

   // Samples stall_o at the falling edge, where it is settled
   task automatic wait_while_stalled(output int cycles);
      int waited;
      waited = 0;
      @(negedge clk);
      while (stall_o && (waited < 50))
      begin
         @(negedge clk);
         waited++;
      end
      cycles = waited;
      if (stall_o)
      begin
         $display("Timeout: stall_o stayed high for 50 cycles");
         $display("Test failures found");
         $finish;
      end
   endtask

   // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task automatic issue_op(input logic rd, input logic wr, input logic [4:0] waddr,
                           input logic [31:0] wdata, input logic [31:0] addr,
                           input logic [2:0] sel);
      int stall_cycles;
      int exp_stall;
      exp_stall = 0;                           // ALU op passes straight through
      if (rd)
         exp_stall = DMEM_WAIT_CYCLES + 1;     // Grant wait, then read data
      else if (wr)
         exp_stall = DMEM_WAIT_CYCLES;
      m_regfile_waddr_i       = waddr;
      m_regfile_rd_i          = wdata;
      m_regfile_wr_i          = !wr;     // ALU ops and loads write back
      m_data_rd_i             = rd;
      m_data_wr_i             = wr;
      m_data_addr_i           = addr;
      m_data_write_transfer_i = sel[1:0];
      m_load_op_i             = sel;
      m_is_load_store_i       = rd | wr;
      wait_while_stalled(stall_cycles);
      test_checks++;
      if (stall_cycles != exp_stall)
      begin
         $display("FAIL stall_o cycles: got %h, expected %h", stall_cycles, exp_stall);
         test_errors++;
      end
      @(posedge clk);
      #1;
      drive_idle();                      // Next op may overwrite at once
   endtask

   task automatic check_reg(input logic [4:0] rd, input logic [31:0] expected);
      repeat (3) @(posedge clk);
      #1;
      rf_raddr_i = rd;
      @(negedge clk);
      test_checks++;
      if (rf_rdata_o !== expected)
      begin
         $display("FAIL rf_rdata_o x%0d: got %h, expected %h", rd, rf_rdata_o, expected);
         test_errors++;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic run_random_words(input logic [4:0] first_rd, input logic [31:0] base,
                                   input int count);
      logic [31:0] stored [$];
      logic [31:0] word;
      for (int i = 0; i < count; i++)
      begin
         word = random_word();
         stored.push_back(word);
         issue_op(1'b0, 1'b1, 5'd0, word, base + 4 * i, {1'b0, XFER_WORD});
      end
      for (int i = 0; i < count; i++)
         issue_op(1'b1, 1'b0, first_rd + 5'(i), '0, base + 4 * i, LOAD_LW);
      for (int i = 0; i < count; i++)
         check_reg(first_rd + 5'(i), stored[i]);
   endtask

   task automatic end_test(input int num);
      if (test_errors == 0)
      begin
         $display("Test %0d: PASS, %0d checks", num, test_checks);
         tests_passed++;
      end
      else
      begin
         $display("Test %0d: FAIL, %0d of %0d checks wrong", num, test_errors, test_checks);
         tests_failed++;
      end
      total_errors += test_errors;
      total_checks += test_checks;
      test_errors   = 0;
      test_checks   = 0;
   endtask

   task automatic run_trace(input int fd);
      logic [7:0]  kind;
      logic [31:0] f_rd;
      logic [31:0] f_addr;
      logic [31:0] f_data;
      logic [31:0] f_sel;
      logic [31:0] f_exp;
      string       rest;
      int          n;
      bit          done;
      done = 1'b0;
      while (!done)
      begin
         n = $fscanf(fd, " %c", kind);
         if (n != 1)
            done = 1'b1;
         else if (kind == "#")
            n = $fgets(rest, fd);   // Skip comment line
         else
         begin
            n = $fscanf(fd, " %h %h %h %h %h", f_rd, f_addr, f_data, f_sel, f_exp);
            if (n != 5)
            begin
               $display("Trace line of kind %c has missing fields", kind);
               test_errors++;
               done = 1'b1;
            end
            else
            begin
               case (kind)
                  "A", "S", "L":
                     issue_op(kind == "L", kind == "S", f_rd[4:0], f_data, f_addr, f_sel[2:0]);
                  "R":
                     check_reg(f_rd[4:0], f_exp);
                  "N":
                     run_random_words(f_rd[4:0], f_addr, f_data);
                  "E":
                     end_test(f_rd);
                  default:
                  begin
                     $display("Unknown trace kind %c", kind);
                     test_errors++;
                  end
               endcase
            end
         end
      end
   endtask

   initial
   begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      rf_raddr_i = '0;
      drive_idle();
      repeat (8) @(posedge clk);
      #1;
      rst_n    = 1'b1;
      trace_fd = $fopen("dv/lsu_trace.txt", "r");
      if (trace_fd == 0)
      begin
         $display("Could not open the trace file dv/lsu_trace.txt");
         total_errors++;
      end
      else
      begin
         run_trace(trace_fd);
         $fclose(trace_fd);
      end
      total_errors += test_errors;   // Errors after the last finished test
      $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
               tests_passed, tests_failed, total_checks, total_errors);
      if ((total_errors == 0) && (tests_failed == 0))
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/lsu_trace.txt ====
# kind rd addr data sel expect, all hex. A alu, S store, L load, R check reg, N random, E end test
# sel is the store size (0 byte, 1 half, 2 word) or the load kind (RISC-V funct3)
A 05 000 12345678 0 0
R 05 000 0 0 12345678
A 00 000 deadbeef 0 0
R 00 000 0 0 0
A 1f 000 cafef00d 0 0
R 1f 000 0 0 cafef00d
E 01 0 0 0 0
S 00 100 a5a55a5a 2 0
L 06 100 0 2 0
R 06 000 0 0 a5a55a5a
E 02 0 0 0 0
S 00 200 11223344 2 0
S 00 201 123456ee 0 0
S 00 202 aaaabeef 1 0
L 07 200 0 2 0
R 07 000 0 0 beefee44
E 03 0 0 0 0
S 00 300 80ff7f01 2 0
L 08 300 0 0 0
L 09 301 0 0 0
L 0a 302 0 0 0
L 0b 303 0 0 0
L 0c 300 0 4 0
L 0d 301 0 4 0
L 0e 302 0 4 0
L 0f 303 0 4 0
L 10 300 0 1 0
L 11 302 0 1 0
L 12 300 0 5 0
L 13 302 0 5 0
R 08 000 0 0 00000001
R 09 000 0 0 0000007f
R 0a 000 0 0 ffffffff
R 0b 000 0 0 ffffff80
R 0c 000 0 0 00000001
R 0d 000 0 0 0000007f
R 0e 000 0 0 000000ff
R 0f 000 0 0 00000080
R 10 000 0 0 00007f01
R 11 000 0 0 ffff80ff
R 12 000 0 0 00007f01
R 13 000 0 0 000080ff
E 04 0 0 0 0
N 0a 380 8 0 0
E 05 0 0 0 0
S 00 3f0 0badf00d 2 0
L 14 3f0 0 2 0
A 15 000 00c0ffee 0 0
R 14 000 0 0 0badf00d
R 15 000 0 0 00c0ffee
E 06 0 0 0 0

// ==== tb.f ====
design/core_pkg.sv
design/data_sram.sv
design/core_mem_stage.sv
design/core_wb_stage.sv
design/core_regfile.sv
design/core_lsu_top.sv
dv/tb_core_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module tb_core_lsu -f tb.f -o tb_core_lsu \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_core_lsu 2>&1 | tee sim.log
[ -s sim.log ] || { echo "No simulation log written"; exit 1; }
grep -q "Test failures found" sim.log \
   && { echo "Simulation FAILED, see sim.log"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }
